/* tb.f */
+incdir+hw
hw/float_pkg.sv
hw/float_align_stage.sv
hw/float_add_stage.sv
hw/float_norm_stage.sv
hw/float_add_pipeline.sv
dv/float_add_assertions.sv
dv/float_add_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the float adder testbench with Verilator and run it
# the result is read from the simulation log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f tb.f --top-module float_add_tb -Mdir obj_dir -o float_add_sim \
    > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/float_add_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$SIM_LOG"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0

/* dv/float_add_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// drives float_add_pipeline with directed and LCG operands
// exponents stay in 32..223, so no result exponent wraps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module float_add_tb
    import float_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        rst;
    logic        req;
    float_word_t a_in;
    float_word_t b_in;
    float_word_t out;
    logic        ack;

    logic [31:0] seed;
    logic [31:0] expected_word;
    logic [31:0] exp_q[$];
    int          errors;
    int          checks;

    float_add_pipeline UUT (.clk(clk), .rst(rst), .req(req), .a(a_in), .b(b_in),
                            .out(out), .ack(ack));

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // random sign and mantissa, exponent in 32..223
    function automatic logic [31:0] rand_float();
        logic [31:0] r;
        logic [31:0] s;
        r = next_rand();
        s = next_rand();
        return {r[31], 8'd32 + 8'(s[31:16] % 16'd192), r[30:8]};
    endfunction

    // expected sum with hidden one always set, truncating shifts and no rounding
    function automatic logic [31:0] ref_add(input logic [31:0] x, input logic [31:0] y);
        logic        s;
        logic [7:0]  e;
        logic [7:0]  diff;
        logic [24:0] mx;
        logic [24:0] my;
        logic [24:0] sum;
        mx = {2'b01, x[22:0]};
        my = {2'b01, y[22:0]};
        if (x[30:23] > y[30:23]) begin
            e    = x[30:23];
            diff = x[30:23] - y[30:23];
            my   = (diff >= 8'd25) ? '0 : my >> diff;
        end else begin
            e    = y[30:23];
            diff = y[30:23] - x[30:23];
            mx   = (diff >= 8'd25) ? '0 : mx >> diff;
        end
        // larger magnitude gives the sign and a tie goes to y
        if (x[31] == y[31]) begin
            sum = mx + my;
            s   = x[31];
        end else if (mx > my) begin
            sum = mx - my;
            s   = x[31];
        end else begin
            sum = my - mx;
            s   = y[31];
        end
        if (sum[24]) begin
            sum = sum >> 1;
            e   = e + 8'd1;
        end
        if (sum == '0) begin
            return 32'h0;
        end
        // walk the leading one up to the hidden position
        while (!sum[23]) begin
            sum = sum << 1;
            e   = e - 8'd1;
        end
        return {s, e, sum[22:0]};
    endfunction

    // one request with inputs changed 2 ns after the edge
    task automatic drive_op(input logic [31:0] x, input logic [31:0] y,
                            input logic [31:0] expected);
        req       = 1'b1;
        a_in.bits = x;
        b_in.bits = y;
        exp_q.push_back(expected);
        @(posedge clk);
        #2;
        req       = 1'b0;
        a_in.bits = '0;
        b_in.bits = '0;
    endtask

    // wait for outstanding results, then report the test
    task automatic finish_test(input string name);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 20) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d results of test %s never came back", exp_q.size(), name);
            errors++;
            exp_q.delete();
        end
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    // kind 0 same sign, 1 opposite sign close, 2 exact cancel, 3 far align, 4 random
    task automatic run_test(input int kind, input int count, input string name);
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] r;
        logic [31:0] expected;
        for (int i = 0; i < count; i++) begin
            x = rand_float();
            y = rand_float();
            r = next_rand();
            case (kind)
                // xor in the low 3 bits keeps the exponent inside 32..223
                0: y = {x[31], (i % 2 == 0) ? x[30:23] : (x[30:23] ^ {5'b0, r[2:0]}), y[22:0]};
                1: y = {~x[31], (i % 2 == 0) ? x[30:23] : (x[30:23] ^ 8'd1),
                        x[22:0] ^ {15'b0, r[7:0]}};
                2: y = x ^ 32'h8000_0000;
                3: begin
                    x[30:23] = 8'd100 + 8'(r[23:16] % 8'd124);
                    y[30:23] = x[30:23] - 8'd25 - {3'b0, r[4:0]};
                end
                default: ;
            endcase
            expected = ref_add(x, y);
            if (kind == 2) expected = 32'h0;
            if (kind == 3) expected = x;
            // far operand on either side
            if (kind == 3 && i % 2 == 1) drive_op(y, x, expected);
            else drive_op(x, y, expected);
            if (kind == 4 && r[31:29] == 3'd0) begin
                @(posedge clk);
                #2;
            end
        end
        finish_test(name);
    endtask

    // scoreboard sampled mid-cycle where out and ack are stable
    always @(negedge clk) begin
        if (!rst && ack) begin
            if (exp_q.size() == 0) begin
                $display("ack at %0t with no request outstanding", $time);
                errors++;
            end else begin
                expected_word = exp_q.pop_front();
                checks++;
                assert (out.bits == expected_word) else begin
                    $display("MISMATCH time=%0t signal=out expected=%h actual=%h",
                             $time, expected_word, out.bits);
                    errors++;
                end
            end
        end
    end

    initial begin
        seed      = 32'd67711;
        errors    = 0;
        checks    = 0;
        rst       = 1'b1;
        req       = 1'b0;
        a_in.bits = '0;
        b_in.bits = '0;
        // reset held for 4 cycles with quiet outputs checked through it and after
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #2;
            assert (ack == 1'b0) else begin
                $display("MISMATCH time=%0t signal=ack expected=0 actual=%b", $time, ack);
                errors++;
            end
            assert (out.bits == '0) else begin
                $display("MISMATCH time=%0t signal=out expected=%h actual=%h",
                         $time, 32'h0, out.bits);
                errors++;
            end
            if (i == 3) rst = 1'b0;
        end
        finish_test("reset_quiescence");
        run_test(0, 24, "same_sign_carry");
        run_test(1, 24, "opposite_sign_cancel");
        run_test(2, 12, "exact_cancel");
        run_test(3, 12, "far_alignment");
        run_test(4, 200, "back_to_back");
        $display("summary: %0d results checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // whole-run limit
    initial begin
        #100_000;
        $display("simulation did not finish within 100 us");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/float_add_assertions.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// req/ack timing and output quiescence of float_add_pipeline
// all properties are off while rst is high
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module float_add_assertions
    import float_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        req,
    input float_word_t out,
    input logic        ack
);

    timeunit 1ns;
    timeprecision 100ps;

    // every request comes back three cycles later
    req_gives_ack: assert property (@(posedge clk) disable iff (rst) req |-> ##3 ack)
        else $error("ack missing three cycles after req");

    // no ack without a matching request
    ack_has_req: assert property (@(posedge clk) disable iff (rst) ack |-> $past(req, 3))
        else $error("ack without a req three cycles earlier");

    // idle cycles carry the zero word
    out_quiet: assert property (@(posedge clk) disable iff (rst) !ack |-> out.bits == '0)
        else $error("out nonzero while ack is low");

    outputs_known: assert property (@(posedge clk) disable iff (rst)
                                    !$isunknown({ack, out.bits}))
        else $error("ack or out unknown");

endmodule

bind float_add_pipeline float_add_assertions u_checks (
    .clk (clk),
    .rst (rst),
    .req (req),
    .out (out),
    .ack (ack)
);

`default_nettype wire

/* hw/float_add_pipeline.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// three-stage float adder, ack exactly 3 cycles after req
// no back-pressure: the result is valid only in the ack cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module float_add_pipeline
    import float_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  float_word_t a,
    input  float_word_t b,
    output float_word_t out,
    output logic        ack
);

    aligned_t aligned;
    summed_t  summed;

    // stage 1: unpack and align
    float_align_stage u_align (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .a       (a),
        .b       (b),
        .aligned (aligned)
    );

    // stage 2: signed-magnitude add
    float_add_stage u_add (
        .clk     (clk),
        .rst     (rst),
        .aligned (aligned),
        .summed  (summed)
    );

    // stage 3: normalize and pack
    float_norm_stage u_norm (
        .clk    (clk),
        .rst    (rst),
        .summed (summed),
        .out    (out),
        .ack    (ack)
    );

endmodule

`default_nettype wire

/* hw/float_norm_stage.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// truncating normalize, no rounding; exponent wraps on over/underflow
// out is zero in every cycle that ack is low
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "float_macros.svh"

module float_norm_stage
    import float_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  summed_t     summed,
    output float_word_t out,
    output logic        ack
);

    // hidden-one position in the working mantissa
    localparam int hidden_pos = `FLOAT_MANT_WIDTH;

    logic [`FLOAT_WMANT_WIDTH-1:0]      mant_c;
    logic [`FLOAT_EXP_WIDTH-1:0]        exp_c;
    logic [`FLOAT_NORM_SHIFT_WIDTH-1:0] norm_shift;
    logic [`FLOAT_WMANT_WIDTH-1:0]      mant_n;
    float_word_t                        result;

    // carry correction
    // the bit dropped here is lost, same as in alignment
    always_comb begin
        mant_c = summed.mant;
        exp_c  = summed.exp;
        if (summed.mant[`FLOAT_WMANT_WIDTH-1]) begin
            mant_c = summed.mant >> 1;
            exp_c  = summed.exp + `FLOAT_EXP_WIDTH'(1);
        end
    end

    // leading-one search below the carry bit
    // scanning upward, so the highest set bit wins
    always_comb begin
        norm_shift = '0;
        for (int i = 0; i <= hidden_pos; i++) begin
            if (mant_c[i]) begin
                norm_shift = `FLOAT_NORM_SHIFT_WIDTH'(hidden_pos - i);
            end
        end
    end

    assign mant_n = mant_c << norm_shift;

    always_comb begin
        result = '0;
        if (mant_c != '0) begin
            result.fields.sign = summed.sign;
            // shift count zero-extended to exponent width
            result.fields.exp  = exp_c - `FLOAT_EXP_WIDTH'(norm_shift);
            result.fields.mant = mant_n[`FLOAT_MANT_WIDTH-1:0];
        end
        // else exact cancel: the all-zero word, sign included
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out <= '0;
            ack <= 1'b0;
        end else begin
            ack <= summed.req;
            if (summed.req) begin
                out <= result;
            end else begin
                out.bits <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/float_add_stage.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// signed-magnitude add of two aligned mantissas
// an exact cancel keeps the sign of b; normalize clears it later
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "float_macros.svh"

module float_add_stage
    import float_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  aligned_t aligned,
    output summed_t  summed
);

    logic    same_sign;
    logic    a_bigger;
    summed_t next_summed;

    assign same_sign = aligned.a_sign == aligned.b_sign;
    // strict compare, equal magnitudes fall to the b side
    assign a_bigger  = aligned.a_mant > aligned.b_mant;

    always_comb begin
        next_summed = '0;
        if (aligned.req) begin
            next_summed.req = 1'b1;
            next_summed.exp = aligned.exp;
            if (same_sign) begin
                // both below 2^24, so the sum fits with the carry bit
                next_summed.sign = aligned.a_sign;
                next_summed.mant = aligned.a_mant + aligned.b_mant;
            end else if (a_bigger) begin
                next_summed.sign = aligned.a_sign;
                next_summed.mant = aligned.a_mant - aligned.b_mant;
            end else begin
                next_summed.sign = aligned.b_sign;
                next_summed.mant = aligned.b_mant - aligned.a_mant;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            summed <= '0;
        end else begin
            summed <= next_summed;
        end
    end

endmodule

`default_nettype wire

/* hw/float_align_stage.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hidden one assumed on both operands, exponent zero included
// bits shifted out of the smaller operand are dropped, no sticky bit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "float_macros.svh"

module float_align_stage
    import float_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  float_word_t a,
    input  float_word_t b,
    output aligned_t    aligned
);

    // shifts from here on push the whole working mantissa out
    localparam logic [`FLOAT_EXP_WIDTH-1:0] max_shift =
        `FLOAT_EXP_WIDTH'(`FLOAT_WMANT_WIDTH);

    logic                          a_larger;
    logic [`FLOAT_EXP_WIDTH-1:0]   big_exp;
    logic [`FLOAT_EXP_WIDTH-1:0]   exp_diff;
    logic [`FLOAT_WMANT_WIDTH-1:0] a_wmant;
    logic [`FLOAT_WMANT_WIDTH-1:0] b_wmant;
    logic [`FLOAT_WMANT_WIDTH-1:0] small_mant;
    logic [`FLOAT_WMANT_WIDTH-1:0] shifted_mant;
    aligned_t                      next_aligned;

    // carry bit clear, hidden one set
    assign a_wmant = {1'b0, 1'b1, a.fields.mant};
    assign b_wmant = {1'b0, 1'b1, b.fields.mant};

    // on a tie b counts as larger, so a gets the zero shift
    assign a_larger = a.fields.exp > b.fields.exp;
    assign big_exp  = a_larger ? a.fields.exp : b.fields.exp;
    assign exp_diff = a_larger ? a.fields.exp - b.fields.exp
                               : b.fields.exp - a.fields.exp;

    // one shifter, fed with whichever operand is smaller
    assign small_mant   = a_larger ? b_wmant : a_wmant;
    assign shifted_mant = (exp_diff >= max_shift) ? '0 : small_mant >> exp_diff;

    always_comb begin
        // idle slot leaves everything zero
        next_aligned = '0;
        if (req) begin
            next_aligned.req    = 1'b1;
            next_aligned.a_sign = a.fields.sign;
            next_aligned.b_sign = b.fields.sign;
            next_aligned.exp    = big_exp;
            next_aligned.a_mant = a_larger ? a_wmant : shifted_mant;
            next_aligned.b_mant = a_larger ? shifted_mant : b_wmant;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            aligned <= '0;
        end else begin
            aligned <= next_aligned;
        end
    end

endmodule

`default_nettype wire

/* hw/float_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types shared by the adder stages
// no special values: every word is a normal number with hidden one
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "float_macros.svh"

package float_pkg;

    // field view of a float word, msb first
    typedef struct packed {
        logic                          sign;
        logic [`FLOAT_EXP_WIDTH-1:0]   exp;
        logic [`FLOAT_MANT_WIDTH-1:0]  mant;
    } float_fields_t;

    // same 32 bits, read raw or as fields
    typedef union packed {
        logic [`FLOAT_WIDTH-1:0]  bits;
        float_fields_t            fields;
    } float_word_t;

    // align -> add
    // both mantissas already on the common (larger) exponent
    typedef struct packed {
        logic                          a_sign;
        logic                          b_sign;
        logic [`FLOAT_EXP_WIDTH-1:0]   exp;
        logic [`FLOAT_WMANT_WIDTH-1:0] a_mant;
        logic [`FLOAT_WMANT_WIDTH-1:0] b_mant;
        logic                          req;
    } aligned_t;

    // add -> norm
    // mant may carry into the top bit, or have lost leading ones
    typedef struct packed {
        logic                          sign;
        logic [`FLOAT_EXP_WIDTH-1:0]   exp;
        logic [`FLOAT_WMANT_WIDTH-1:0] mant;
        logic                          req;
    } summed_t;

endpackage

`default_nettype wire

/* hw/float_macros.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// field widths of the single-precision word and the working mantissa
// changing these does not give another IEEE format, only other widths
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef FLOAT_MACROS_SVH
`define FLOAT_MACROS_SVH

// whole word, sign + exponent + stored mantissa
`define FLOAT_WIDTH 32
`define FLOAT_EXP_WIDTH 8
`define FLOAT_MANT_WIDTH 23

// working mantissa: [carry][hidden one][stored mantissa]
`define FLOAT_WMANT_WIDTH (`FLOAT_MANT_WIDTH + 2)

// left shift count in normalize, covers 0..23
`define FLOAT_NORM_SHIFT_WIDTH 5

`endif
